//--- build.f
+incdir+verif
logic/gtePkg.sv
logic/gteDecode.sv
logic/gteExecute.sv
logic/gteResult.sv
logic/gteRegisters.sv
logic/gteEngine.sv
verif/gteEngineTb.sv

//--- logic/gteDecode.sv
`timescale 1ns/1ps

module gteDecode #(
	parameter int OPCODE_W = 6
) (
	input  logic              i_clk,
	input  logic              i_resetStatus,
	input  logic [24:0]       i_instruction,
	input  logic              i_execute,
	output logic              o_executing,
	output gtePkg::microOp_e  o_microOp,
	output gtePkg::operand_e  o_opA,
	output gtePkg::operand_e  o_opB,
	output logic              o_clearAcc,
	output logic              o_lastStep,   // Last product of a group
	output gtePkg::dest_e     o_dest,
	output logic              o_sf,
	output logic              o_lm,
	output logic              o_cmdStart
);

	localparam int AW = gtePkg::MICRO_ADDR_W;
	localparam logic [AW-1:0] ADDR_NCLIP = 4'd0;   // 6 entries
	localparam logic [AW-1:0] ADDR_SQR   = 4'd6;   // 3 entries
	localparam logic [AW-1:0] ADDR_AVSZ3 = 4'd9;   // 3 MACs, then OTZ write
	localparam logic [AW-1:0] ADDR_NOP   = 4'd13;
	localparam logic [AW-1:0] ROM_LAST   = 4'd13;

	logic [AW-1:0] pc, startAddr;
	logic          running;
	logic [1:0]    doneSr;    // Tracks final step through execute and result
	logic [5:0]    opcode;

	gtePkg::microOp_e romMop;
	gtePkg::operand_e romA, romB;
	gtePkg::dest_e    romDest;
	logic             romClear, romLast, romEnd;

	assign opcode     = 6'(i_instruction[OPCODE_W-1:0]);
	assign o_cmdStart = i_execute && !o_executing;
	assign o_executing = running || (|doneSr);

	always_comb begin
		case (opcode)
			gtePkg::OP_NCLIP: startAddr = ADDR_NCLIP;
			gtePkg::OP_SQR:   startAddr = ADDR_SQR;
			gtePkg::OP_AVSZ3: startAddr = ADDR_AVSZ3;
			default:          startAddr = ADDR_NOP;   // Unknown opcode
		endcase
	end

	// --------------------------------------------------
	// Microcode ROM
	// --------------------------------------------------
	always_comb begin
		romMop = gtePkg::MOP_MAC_ADD;
		romA = gtePkg::OPD_SX0;
		romB = gtePkg::OPD_SY0;
		romClear = 1'b0;
		romLast = 1'b0;
		romEnd = 1'b0;
		romDest = gtePkg::DST_NONE;
		case (pc)
			// NCLIP cross product
			4'd0: begin romA = gtePkg::OPD_SX0; romB = gtePkg::OPD_SY1; romClear = 1'b1; end
			4'd1: begin romA = gtePkg::OPD_SX1; romB = gtePkg::OPD_SY2; end
			4'd2: begin romA = gtePkg::OPD_SX2; romB = gtePkg::OPD_SY0; end
			4'd3: begin romMop = gtePkg::MOP_MAC_SUB; romA = gtePkg::OPD_SX0; romB = gtePkg::OPD_SY2; end
			4'd4: begin romMop = gtePkg::MOP_MAC_SUB; romA = gtePkg::OPD_SX1; romB = gtePkg::OPD_SY0; end
			4'd5: begin
				romMop = gtePkg::MOP_MAC_SUB;
				romA = gtePkg::OPD_SX2;
				romB = gtePkg::OPD_SY1;
				romLast = 1'b1;
				romEnd = 1'b1;
				romDest = gtePkg::DST_MAC0;
			end
			// SQR, one group per lane
			4'd6, 4'd7, 4'd8: begin
				romA = (pc == 4'd6) ? gtePkg::OPD_IR1 : (pc == 4'd7) ? gtePkg::OPD_IR2 : gtePkg::OPD_IR3;
				romB = romA;
				romClear = 1'b1;
				romLast = 1'b1;
				romEnd = (pc == 4'd8);
				romDest = (pc == 4'd6) ? gtePkg::DST_IR1 : (pc == 4'd7) ? gtePkg::DST_IR2 : gtePkg::DST_IR3;
			end
			// AVSZ3 weighted Z sum
			4'd9:  begin romA = gtePkg::OPD_ZSF3; romB = gtePkg::OPD_SZ1; romClear = 1'b1; end
			4'd10: begin romA = gtePkg::OPD_ZSF3; romB = gtePkg::OPD_SZ2; end
			4'd11: begin
				romA = gtePkg::OPD_ZSF3;
				romB = gtePkg::OPD_SZ3;
				romLast = 1'b1;
				romDest = gtePkg::DST_MAC0;
			end
			4'd12: begin   // Same sum again, now to OTZ
				romMop = gtePkg::MOP_NOP;
				romLast = 1'b1;
				romEnd = 1'b1;
				romDest = gtePkg::DST_OTZ;
			end
			default: begin romMop = gtePkg::MOP_NOP; romEnd = 1'b1; end
		endcase
	end

	// Idle cycles issue plain NOPs
	assign o_microOp  = running ? romMop : gtePkg::MOP_NOP;
	assign o_opA      = romA;
	assign o_opB      = romB;
	assign o_clearAcc = running && romClear;
	assign o_lastStep = running && romLast;
	assign o_dest     = running ? romDest : gtePkg::DST_NONE;

	// --------------------------------------------------
	// Sequencer
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetStatus) begin
			running <= 1'b0;
			doneSr <= 2'b00;
			pc <= ADDR_NOP;
		end else begin
			doneSr <= {doneSr[0], running && romEnd};
			if (o_cmdStart) begin
				running <= 1'b1;
				pc <= startAddr;
			end else if (running) begin
				if (romEnd) running <= 1'b0;
				else pc <= pc + 1'b1;   // Next entry
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_cmdStart) begin
			o_sf <= i_instruction[19];   // 12 bit fraction shift
			o_lm <= i_instruction[10];   // Clamp IR to zero
		end
	end

	// Program stays inside the filled part of the ROM
	assert property (@(posedge i_clk) disable iff (i_resetStatus)
		running && !romEnd |=> running && (pc <= ROM_LAST));

endmodule

//--- logic/gteEngine.sv
`timescale 1ns/1ps

module gteEngine #(
	parameter int OPCODE_W = 6
) (
	input  logic            i_clk,
	input  logic            i_resetStatus,
	input  gtePkg::regId_t  i_regId,
	input  logic            i_writeReg,
	input  logic            i_readReg,
	input  gtePkg::word_t   i_dataIn,
	input  logic [24:0]     i_instruction,
	input  logic            i_execute,
	output gtePkg::word_t   o_dataOut,
	output logic            o_executing
);

	// Decode to execute
	gtePkg::microOp_e microOp;
	gtePkg::operand_e opA, opB;
	gtePkg::dest_e    stepDest, accDest, wrDest;
	logic             clearAcc, lastStep, sf, lm, cmdStart;

	// Execute to result to registers
	gtePkg::acc_t  acc;
	gtePkg::word_t wrValue, flag;
	logic          accValid, wrStrobe;

	// Register bank to execute
	gtePkg::half_t sx0, sx1, sx2, sy0, sy1, sy2;
	gtePkg::half_t sz1, sz2, sz3, ir1, ir2, ir3, zsf3;

	gteDecode #(.OPCODE_W(OPCODE_W)) gteDecode_inst (
		.i_clk(i_clk), .i_resetStatus(i_resetStatus),
		.i_instruction(i_instruction), .i_execute(i_execute),
		.o_executing(o_executing), .o_microOp(microOp),
		.o_opA(opA), .o_opB(opB), .o_clearAcc(clearAcc), .o_lastStep(lastStep),
		.o_dest(stepDest), .o_sf(sf), .o_lm(lm), .o_cmdStart(cmdStart)
	);

	gteExecute gteExecute_inst (
		.i_clk(i_clk), .i_resetStatus(i_resetStatus),
		.i_microOp(microOp), .i_opA(opA), .i_opB(opB),
		.i_clearAcc(clearAcc), .i_lastStep(lastStep), .i_dest(stepDest),
		.i_sx0(sx0), .i_sx1(sx1), .i_sx2(sx2), .i_sy0(sy0), .i_sy1(sy1), .i_sy2(sy2),
		.i_sz1(sz1), .i_sz2(sz2), .i_sz3(sz3), .i_ir1(ir1), .i_ir2(ir2), .i_ir3(ir3),
		.i_zsf3(zsf3), .o_accValid(accValid), .o_acc(acc), .o_dest(accDest)
	);

	gteResult gteResult_inst (
		.i_clk(i_clk), .i_resetStatus(i_resetStatus),
		.i_accValid(accValid), .i_acc(acc), .i_dest(accDest),
		.i_sf(sf), .i_lm(lm), .i_cmdStart(cmdStart),
		.o_wrStrobe(wrStrobe), .o_wrDest(wrDest), .o_wrValue(wrValue), .o_flag(flag)
	);

	gteRegisters gteRegisters_inst (
		.i_clk(i_clk), .i_resetStatus(i_resetStatus),
		.i_regId(i_regId), .i_writeReg(i_writeReg), .i_readReg(i_readReg),
		.i_dataIn(i_dataIn), .i_executing(o_executing),
		.i_wrStrobe(wrStrobe), .i_wrDest(wrDest), .i_wrValue(wrValue), .i_flag(flag),
		.o_dataOut(o_dataOut),
		.o_sx0(sx0), .o_sx1(sx1), .o_sx2(sx2), .o_sy0(sy0), .o_sy1(sy1), .o_sy2(sy2),
		.o_sz1(sz1), .o_sz2(sz2), .o_sz3(sz3), .o_ir1(ir1), .o_ir2(ir2), .o_ir3(ir3),
		.o_zsf3(zsf3)
	);

endmodule

//--- logic/gteExecute.sv
`timescale 1ns/1ps

module gteExecute (
	input  logic              i_clk,
	input  logic              i_resetStatus,
	input  gtePkg::microOp_e  i_microOp,
	input  gtePkg::operand_e  i_opA,
	input  gtePkg::operand_e  i_opB,
	input  logic              i_clearAcc,
	input  logic              i_lastStep,
	input  gtePkg::dest_e     i_dest,
	input  gtePkg::half_t     i_sx0,
	input  gtePkg::half_t     i_sx1,
	input  gtePkg::half_t     i_sx2,
	input  gtePkg::half_t     i_sy0,
	input  gtePkg::half_t     i_sy1,
	input  gtePkg::half_t     i_sy2,
	input  gtePkg::half_t     i_sz1,
	input  gtePkg::half_t     i_sz2,
	input  gtePkg::half_t     i_sz3,
	input  gtePkg::half_t     i_ir1,
	input  gtePkg::half_t     i_ir2,
	input  gtePkg::half_t     i_ir3,
	input  gtePkg::half_t     i_zsf3,
	output logic              o_accValid,
	output gtePkg::acc_t      o_acc,
	output gtePkg::dest_e     o_dest
);

	logic signed [16:0] valA, valB;   // One extra bit for unsigned SZ
	logic signed [33:0] product;
	gtePkg::acc_t       prodExt, base, accNext;

	// Operand mux, SZ values are unsigned depths
	function automatic logic signed [16:0] pick(input gtePkg::operand_e sel);
		case (sel)
			gtePkg::OPD_SX0:  return {i_sx0[15], i_sx0};
			gtePkg::OPD_SX1:  return {i_sx1[15], i_sx1};
			gtePkg::OPD_SX2:  return {i_sx2[15], i_sx2};
			gtePkg::OPD_SY0:  return {i_sy0[15], i_sy0};
			gtePkg::OPD_SY1:  return {i_sy1[15], i_sy1};
			gtePkg::OPD_SY2:  return {i_sy2[15], i_sy2};
			gtePkg::OPD_SZ1:  return {1'b0, i_sz1};
			gtePkg::OPD_SZ2:  return {1'b0, i_sz2};
			gtePkg::OPD_SZ3:  return {1'b0, i_sz3};
			gtePkg::OPD_IR1:  return {i_ir1[15], i_ir1};
			gtePkg::OPD_IR2:  return {i_ir2[15], i_ir2};
			gtePkg::OPD_IR3:  return {i_ir3[15], i_ir3};
			gtePkg::OPD_ZSF3: return {i_zsf3[15], i_zsf3};
			default:          return '0;
		endcase
	endfunction

	// --------------------------------------------------
	// Multiply and accumulate
	// --------------------------------------------------
	always_comb begin
		valA = pick(i_opA);
		valB = pick(i_opB);
		product = valA * valB;
		prodExt = product;                    // Sign extends to 44 bits
		base = i_clearAcc ? '0 : o_acc;       // Restart a group
		case (i_microOp)
			gtePkg::MOP_MAC_ADD: accNext = base + prodExt;
			gtePkg::MOP_MAC_SUB: accNext = base - prodExt;
			default:             accNext = base;
		endcase
	end

	always_ff @(posedge i_clk) begin
		o_acc <= accNext;   // Holds the sum on the valid cycle
		o_dest <= i_dest;
	end

	always_ff @(posedge i_clk) begin
		if (i_resetStatus) o_accValid <= 1'b0;
		else o_accValid <= i_lastStep;   // Group complete
	end

endmodule

//--- logic/gtePkg.sv
package gtePkg;

	// --------------------------------------------------
	// Basic widths
	// --------------------------------------------------
	typedef logic [5:0]         regId_t;   // Bit 5 picks control bank
	typedef logic [31:0]        word_t;    // CPU data word
	typedef logic [15:0]        half_t;    // 16 bit register value
	typedef logic signed [43:0] acc_t;     // MAC accumulator

	localparam int MICRO_ADDR_W = 4;       // 16 entry microcode ROM

	// --------------------------------------------------
	// Register numbers seen by the CPU
	// --------------------------------------------------
	localparam regId_t REG_OTZ  = 6'd7;
	localparam regId_t REG_IR0  = 6'd8;
	localparam regId_t REG_IR1  = 6'd9;
	localparam regId_t REG_IR2  = 6'd10;
	localparam regId_t REG_IR3  = 6'd11;
	localparam regId_t REG_SXY0 = 6'd12;
	localparam regId_t REG_SXY1 = 6'd13;
	localparam regId_t REG_SXY2 = 6'd14;
	localparam regId_t REG_SXYP = 6'd15;   // Push slot of XY FIFO
	localparam regId_t REG_SZ0  = 6'd16;
	localparam regId_t REG_SZ1  = 6'd17;
	localparam regId_t REG_SZ2  = 6'd18;
	localparam regId_t REG_SZ3  = 6'd19;
	localparam regId_t REG_MAC0 = 6'd24;
	localparam regId_t REG_IRGB = 6'd28;   // Mirror of ORGB on read
	localparam regId_t REG_ORGB = 6'd29;
	localparam regId_t REG_LZCS = 6'd30;
	localparam regId_t REG_LZCR = 6'd31;
	localparam regId_t REG_ZSF3 = 6'd61;   // Control bank
	localparam regId_t REG_FLAG = 6'd63;

	// Command opcodes kept from the full engine
	typedef enum logic [5:0] {
		OP_NCLIP = 6'h06,
		OP_SQR   = 6'h28,
		OP_AVSZ3 = 6'h2D
	} opcode_e;

	// Micro-operation kinds
	typedef enum logic [1:0] {
		MOP_NOP,       // Accumulator passes through
		MOP_MAC_ADD,
		MOP_MAC_SUB
	} microOp_e;

	// Operand sources for the multiplier
	typedef enum logic [3:0] {
		OPD_SX0, OPD_SX1, OPD_SX2,
		OPD_SY0, OPD_SY1, OPD_SY2,
		OPD_SZ1, OPD_SZ2, OPD_SZ3,
		OPD_IR1, OPD_IR2, OPD_IR3,
		OPD_ZSF3
	} operand_e;

	// Write-back targets
	typedef enum logic [2:0] {
		DST_NONE,
		DST_MAC0,
		DST_OTZ,
		DST_IR1,
		DST_IR2,
		DST_IR3
	} dest_e;

endpackage

//--- logic/gteRegisters.sv
`timescale 1ns/1ps

module gteRegisters (
	input  logic            i_clk,
	input  logic            i_resetStatus,
	input  gtePkg::regId_t  i_regId,
	input  logic            i_writeReg,
	input  logic            i_readReg,
	input  gtePkg::word_t   i_dataIn,
	input  logic            i_executing,
	input  logic            i_wrStrobe,
	input  gtePkg::dest_e   i_wrDest,
	input  gtePkg::word_t   i_wrValue,
	input  gtePkg::word_t   i_flag,
	output gtePkg::word_t   o_dataOut,
	output gtePkg::half_t   o_sx0,
	output gtePkg::half_t   o_sx1,
	output gtePkg::half_t   o_sx2,
	output gtePkg::half_t   o_sy0,
	output gtePkg::half_t   o_sy1,
	output gtePkg::half_t   o_sy2,
	output gtePkg::half_t   o_sz1,
	output gtePkg::half_t   o_sz2,
	output gtePkg::half_t   o_sz3,
	output gtePkg::half_t   o_ir1,
	output gtePkg::half_t   o_ir2,
	output gtePkg::half_t   o_ir3,
	output gtePkg::half_t   o_zsf3
);

	gtePkg::half_t  sx [3];     // XY FIFO, slot 2 newest
	gtePkg::half_t  sy [3];
	gtePkg::half_t  sz [4];
	gtePkg::half_t  ir [4];
	gtePkg::half_t  zsf3, otz;
	gtePkg::word_t  mac0, lzcs, readMux;
	logic [5:0]     lzcr;
	logic [14:0]    orgb;
	gtePkg::regId_t rdId;
	logic           rdPending;

	// Sign bits equal to bit 31, counts 1..32
	function automatic logic [5:0] leadCount(input gtePkg::word_t v);
		logic [5:0] n;
		logic       stop;
		n = 6'd0;
		stop = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (!stop && v[i] == v[31]) n = n + 1'b1;
			else stop = 1'b1;
		end
		return n;
	endfunction

	// 5 bit colour field from one IR lane
	function automatic logic [4:0] colour(input gtePkg::half_t v);
		if (v[15]) return 5'd0;              // Negative goes black
		else if (|v[14:12]) return 5'd31;    // Saturate
		else return v[11:7];
	endfunction

	// --------------------------------------------------
	// Write side, CPU and command write-back
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_writeReg) begin
			case (i_regId)
				gtePkg::REG_SXY0, gtePkg::REG_SXY1, gtePkg::REG_SXY2: begin
					sx[i_regId[1:0]] <= i_dataIn[15:0];   // 12..14 map to 0..2
					sy[i_regId[1:0]] <= i_dataIn[31:16];
				end
				gtePkg::REG_SXYP: begin   // Shift FIFO, new value in slot 2
					sx[0] <= sx[1];
					sx[1] <= sx[2];
					sx[2] <= i_dataIn[15:0];
					sy[0] <= sy[1];
					sy[1] <= sy[2];
					sy[2] <= i_dataIn[31:16];
				end
				gtePkg::REG_SZ0, gtePkg::REG_SZ1,
				gtePkg::REG_SZ2, gtePkg::REG_SZ3: sz[i_regId[1:0]] <= i_dataIn[15:0];
				gtePkg::REG_IR0, gtePkg::REG_IR1,
				gtePkg::REG_IR2, gtePkg::REG_IR3: ir[i_regId[1:0]] <= i_dataIn[15:0];
				gtePkg::REG_OTZ:  otz <= i_dataIn[15:0];
				gtePkg::REG_MAC0: mac0 <= i_dataIn;
				gtePkg::REG_ZSF3: zsf3 <= i_dataIn[15:0];
				gtePkg::REG_LZCS: begin
					lzcs <= i_dataIn;
					lzcr <= leadCount(i_dataIn);
				end
				default: ;   // Read-only or dropped registers
			endcase
		end
		if (i_wrStrobe) begin
			case (i_wrDest)
				gtePkg::DST_MAC0: mac0 <= i_wrValue;
				gtePkg::DST_OTZ:  otz <= i_wrValue[15:0];
				gtePkg::DST_IR1:  ir[1] <= i_wrValue[15:0];
				gtePkg::DST_IR2:  ir[2] <= i_wrValue[15:0];
				gtePkg::DST_IR3:  ir[3] <= i_wrValue[15:0];
				default: ;
			endcase
		end
	end

	assign orgb = {colour(ir[3]), colour(ir[2]), colour(ir[1])};   // B,G,R

	// --------------------------------------------------
	// Read side, one cycle behind the strobe
	// --------------------------------------------------
	always_comb begin
		case (rdId)
			gtePkg::REG_OTZ:  readMux = {16'b0, otz};
			gtePkg::REG_IR0, gtePkg::REG_IR1, gtePkg::REG_IR2, gtePkg::REG_IR3:
				readMux = {{16{ir[rdId[1:0]][15]}}, ir[rdId[1:0]]};
			gtePkg::REG_SXY0, gtePkg::REG_SXY1, gtePkg::REG_SXY2:
				readMux = {sy[rdId[1:0]], sx[rdId[1:0]]};
			gtePkg::REG_SXYP: readMux = {sy[2], sx[2]};   // Read does not shift
			gtePkg::REG_SZ0, gtePkg::REG_SZ1, gtePkg::REG_SZ2, gtePkg::REG_SZ3:
				readMux = {16'b0, sz[rdId[1:0]]};
			gtePkg::REG_MAC0: readMux = mac0;
			gtePkg::REG_IRGB, gtePkg::REG_ORGB: readMux = {17'b0, orgb};
			gtePkg::REG_LZCS: readMux = lzcs;
			gtePkg::REG_LZCR: readMux = {26'b0, lzcr};
			gtePkg::REG_ZSF3: readMux = {{16{zsf3[15]}}, zsf3};
			gtePkg::REG_FLAG: readMux = i_flag;
			default:          readMux = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_resetStatus) rdPending <= 1'b0;
		else rdPending <= i_readReg;
	end

	always_ff @(posedge i_clk) begin
		if (i_readReg) rdId <= i_regId;
		if (rdPending) o_dataOut <= readMux;   // Held until next read
	end

	assign o_sx0 = sx[0];
	assign o_sx1 = sx[1];
	assign o_sx2 = sx[2];
	assign o_sy0 = sy[0];
	assign o_sy1 = sy[1];
	assign o_sy2 = sy[2];
	assign o_sz1 = sz[1];
	assign o_sz2 = sz[2];
	assign o_sz3 = sz[3];
	assign o_ir1 = ir[1];
	assign o_ir2 = ir[2];
	assign o_ir3 = ir[3];
	assign o_zsf3 = zsf3;

	// CPU keeps off the bus while a command runs
	assert property (@(posedge i_clk) disable iff (i_resetStatus)
		i_executing |-> !(i_writeReg || i_readReg));

endmodule

//--- logic/gteResult.sv
`timescale 1ns/1ps

module gteResult (
	input  logic           i_clk,
	input  logic           i_resetStatus,
	input  logic           i_accValid,
	input  gtePkg::acc_t   i_acc,
	input  gtePkg::dest_e  i_dest,
	input  logic           i_sf,
	input  logic           i_lm,
	input  logic           i_cmdStart,
	output logic           o_wrStrobe,
	output gtePkg::dest_e  o_wrDest,
	output gtePkg::word_t  o_wrValue,
	output gtePkg::word_t  o_flag
);

	gtePkg::acc_t  shifted, irLow, irVal, otzShift, otzVal;
	gtePkg::word_t value;
	logic          irSat, otzSat;
	logic          flagIr1, flagIr2, flagIr3, flagOtz;   // Sticky saturation bits

	// --------------------------------------------------
	// Shift and clamp
	// --------------------------------------------------
	always_comb begin
		shifted = i_sf ? (i_acc >>> 12) : i_acc;
		irLow = i_lm ? 44'sd0 : -44'sd32768;   // lm raises floor to zero
		irSat = (shifted > 32767) || (shifted < irLow);
		if (shifted > 32767) irVal = 44'sd32767;
		else if (shifted < irLow) irVal = irLow;
		else irVal = shifted;

		otzShift = i_acc >>> 12;   // OTZ always drops the fraction
		otzSat = (otzShift > 65535) || (otzShift < 0);
		if (otzShift > 65535) otzVal = 44'sd65535;
		else if (otzShift < 0) otzVal = '0;
		else otzVal = otzShift;

		case (i_dest)
			gtePkg::DST_MAC0: value = i_acc[31:0];   // Low word only
			gtePkg::DST_OTZ:  value = otzVal[31:0];
			default:          value = irVal[31:0];   // Sign extended IR
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_resetStatus) o_wrStrobe <= 1'b0;
		else o_wrStrobe <= i_accValid && (i_dest != gtePkg::DST_NONE);
	end

	always_ff @(posedge i_clk) begin
		o_wrDest <= i_dest;
		o_wrValue <= value;
	end

	// --------------------------------------------------
	// FLAG register
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetStatus || i_cmdStart) begin   // New command starts clean
			flagIr1 <= 1'b0;
			flagIr2 <= 1'b0;
			flagIr3 <= 1'b0;
			flagOtz <= 1'b0;
		end else if (i_accValid) begin
			if (irSat && i_dest == gtePkg::DST_IR1) flagIr1 <= 1'b1;
			if (irSat && i_dest == gtePkg::DST_IR2) flagIr2 <= 1'b1;
			if (irSat && i_dest == gtePkg::DST_IR3) flagIr3 <= 1'b1;
			if (otzSat && i_dest == gtePkg::DST_OTZ) flagOtz <= 1'b1;
		end
	end

	// Bit 31 summarises the error bits
	assign o_flag = {flagIr1 | flagIr2 | flagIr3 | flagOtz, 6'b0,
		flagIr1, flagIr2, flagIr3, 3'b0, flagOtz, 18'b0};

endmodule

//--- verif/gteTbModel.svh
`ifndef GTE_TB_MODEL_SVH
`define GTE_TB_MODEL_SVH

// --------------------------------------------------
// Register file rules
// --------------------------------------------------

// Value a CPU read returns after a plain write
function automatic gtePkg::word_t readBack(input gtePkg::regId_t id, input gtePkg::word_t data);
	case (id)
		gtePkg::REG_IR0, gtePkg::REG_IR1, gtePkg::REG_IR2, gtePkg::REG_IR3, gtePkg::REG_ZSF3:
			return {{16{data[15]}}, data[15:0]};   // Signed halves
		gtePkg::REG_SZ0, gtePkg::REG_SZ1, gtePkg::REG_SZ2, gtePkg::REG_SZ3, gtePkg::REG_OTZ:
			return {16'h0000, data[15:0]};         // Unsigned depths
		default:
			return data;                           // MAC0 keeps all bits
	endcase
endfunction

// Run of bits matching the sign bit
function automatic int leadBits(input gtePkg::word_t v);
	int k;
	k = 1;
	while (k < 32 && v[31 - k] == v[31]) k++;
	return k;
endfunction

// One colour channel from an IR lane
function automatic logic [4:0] colourField(input gtePkg::half_t v);
	int s;
	s = $signed(v);
	if (s < 0) return 5'd0;
	if (s >= 4096) return 5'd31;   // Upper magnitude bits set
	return v[11:7];
endfunction

function automatic gtePkg::word_t orgbModel(input gtePkg::half_t r, g, b);
	return {17'b0, colourField(b), colourField(g), colourField(r)};
endfunction

// --------------------------------------------------
// Commands
// --------------------------------------------------

// Twice the signed triangle area
function automatic gtePkg::word_t nclipModel(input gtePkg::half_t x0, x1, x2, y0, y1, y2);
	longint a0, a1, a2, b0, b1, b2, area;
	a0 = $signed(x0);
	a1 = $signed(x1);
	a2 = $signed(x2);
	b0 = $signed(y0);
	b1 = $signed(y1);
	b2 = $signed(y2);
	area = a0 * (b1 - b2) + a1 * (b2 - b0) + a2 * (b0 - b1);
	return area[31:0];   // MAC0 keeps the low word
endfunction

// Square of one lane with optional fraction drop
function automatic gtePkg::word_t sqrLane(input gtePkg::half_t ir, input logic sf,
	input logic lm, output logic sat);
	longint v, lo;
	v = $signed(ir);
	v = v * v;
	if (sf) v = v / 4096;   // Square never negative
	lo = lm ? 0 : -32768;
	sat = (v > 32767) || (v < lo);
	if (v > 32767) v = 32767;
	else if (v < lo) v = lo;
	return v[31:0];
endfunction

// Average Z with ZSF3 weight
function automatic void avsz3Model(input gtePkg::half_t z1, z2, z3, zsf,
	output gtePkg::word_t mac, output gtePkg::half_t otz, output logic sat);
	longint w, a, b, c, sum, q;
	w = $signed(zsf);
	a = z1;
	b = z2;
	c = z3;
	sum = w * (a + b + c);
	q = sum >>> 12;   // Floor of the 12 bit fraction
	mac = sum[31:0];
	sat = (q < 0) || (q > 65535);
	if (q < 0) otz = '0;
	else if (q > 65535) otz = 16'hFFFF;
	else otz = q[15:0];
endfunction

`endif

//--- verif/gteEngineTb.sv
`timescale 1ns/1ps

module gteEngineTb;

	logic           i_clk;
	logic           i_resetStatus;
	gtePkg::regId_t i_regId;
	logic           i_writeReg;
	logic           i_readReg;
	gtePkg::word_t  i_dataIn;
	logic [24:0]    i_instruction;
	logic           i_execute;
	gtePkg::word_t  o_dataOut;
	logic           o_executing;
	logic [31:0]    lfsrState;

	`include "gteTbModel.svh"

	gteEngine #(.OPCODE_W(6)) gteEngine_inst (
		.i_clk(i_clk), .i_resetStatus(i_resetStatus),
		.i_regId(i_regId), .i_writeReg(i_writeReg), .i_readReg(i_readReg),
		.i_dataIn(i_dataIn), .i_instruction(i_instruction), .i_execute(i_execute),
		.o_dataOut(o_dataOut), .o_executing(o_executing)
	);

	always #2 i_clk = ~i_clk;   // 4 ns period

	// --------------------------------------------------
	// Random source, checks and bus tasks
	// --------------------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) return (s >> 1) ^ 32'h80200003;   // Maximal length taps
		else return s >> 1;
	endfunction

	function automatic gtePkg::word_t randBits(input int n);
		gtePkg::word_t r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);   // One step per bit
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input gtePkg::word_t want,
		input gtePkg::word_t got);
		if (got !== want)
			abortRun($sformatf("ERROR at %0d ns: %s expected %h actual %h",
				$time, name, want, got));
	endtask

	task automatic checkHalf(input string name, input gtePkg::half_t want,
		input gtePkg::half_t got);
		if (got !== want)
			abortRun($sformatf("ERROR at %0d ns: %s expected %h actual %h",
				$time, name, want, got));
	endtask

	task automatic cpuWrite(input gtePkg::regId_t id, input gtePkg::word_t data);
		@(posedge i_clk);
		i_regId <= id;
		i_dataIn <= data;
		i_writeReg <= 1'b1;
		@(posedge i_clk);   // Write lands here
		i_writeReg <= 1'b0;
	endtask

	task automatic cpuRead(input gtePkg::regId_t id, output gtePkg::word_t data);
		@(posedge i_clk);
		i_regId <= id;
		i_readReg <= 1'b1;
		@(posedge i_clk);   // Number latched
		i_readReg <= 1'b0;
		@(posedge i_clk);   // Output register loads
		@(negedge i_clk);
		data = o_dataOut;
	endtask

	task automatic runCommand(input logic [5:0] opcode, input logic sf, input logic lm);
		int cycles;
		@(posedge i_clk);
		i_instruction <= {5'b0, sf, 8'b0, lm, 4'b0, opcode};
		i_execute <= 1'b1;
		@(posedge i_clk);
		i_execute <= 1'b0;
		@(negedge i_clk);
		if (!o_executing) abortRun("Command start was not followed by o_executing high");
		cycles = 0;
		while (o_executing) begin   // Drain of all write-backs
			@(negedge i_clk);
			cycles++;
			if (cycles > 64) abortRun("Timeout waiting for o_executing to fall");
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		gtePkg::regId_t ids [11];
		gtePkg::word_t  vals [11];
		gtePkg::word_t  edges [6];
		gtePkg::word_t  got, want, v;
		gtePkg::half_t  fx [3], fy [3], irv [3], sz [3];
		gtePkg::half_t  zsf, otzWant;
		logic           sat [3];
		logic           otzSat, sf, lm;

		i_clk = 1'b0;
		i_resetStatus = 1'b1;
		i_regId = '0;
		i_writeReg = 1'b0;
		i_readReg = 1'b0;
		i_dataIn = '0;
		i_instruction = '0;
		i_execute = 1'b0;
		lfsrState = 32'd53;
		ids = '{gtePkg::REG_IR0, gtePkg::REG_IR1, gtePkg::REG_IR2, gtePkg::REG_IR3,
			gtePkg::REG_SZ0, gtePkg::REG_SZ1, gtePkg::REG_SZ2, gtePkg::REG_SZ3,
			gtePkg::REG_ZSF3, gtePkg::REG_MAC0, gtePkg::REG_OTZ};
		edges = '{32'h0, 32'hFFFFFFFF, 32'h80000000, 32'h7FFFFFFF, 32'h1, 32'hFFFFFFFE};

		repeat (16) @(posedge i_clk);
		i_resetStatus <= 1'b0;
		cpuRead(gtePkg::REG_FLAG, got);
		checkWord("FLAG after reset", '0, got);

		// Write then read back with promotion
		for (int round = 0; round < 2; round++) begin
			for (int k = 0; k < 11; k++) begin
				vals[k] = randBits(32);
				cpuWrite(ids[k], vals[k]);
			end
			for (int k = 0; k < 11; k++) begin
				cpuRead(ids[k], got);
				checkWord($sformatf("reg %0d", ids[k]), readBack(ids[k], vals[k]), got);
			end
		end

		// XY FIFO load and pushes
		for (int k = 0; k < 3; k++) begin
			v = randBits(32);
			fx[k] = v[15:0];
			fy[k] = v[31:16];
			cpuWrite(gtePkg::regId_t'(gtePkg::REG_SXY0 + k), v);
		end
		for (int k = 0; k < 5; k++) begin
			v = randBits(32);
			cpuWrite(gtePkg::REG_SXYP, v);
			fx[0] = fx[1];
			fx[1] = fx[2];
			fx[2] = v[15:0];
			fy[0] = fy[1];
			fy[1] = fy[2];
			fy[2] = v[31:16];
			cpuRead(gtePkg::REG_SXYP, got);
			checkHalf("SXYP x", fx[2], got[15:0]);
			checkHalf("SXYP y", fy[2], got[31:16]);
			for (int j = 0; j < 3; j++) begin   // Older slots after each shift
				cpuRead(gtePkg::regId_t'(gtePkg::REG_SXY0 + j), got);
				checkHalf($sformatf("SX%0d", j), fx[j], got[15:0]);
				checkHalf($sformatf("SY%0d", j), fy[j], got[31:16]);
			end
		end

		// Lead count, edges first
		for (int k = 0; k < 16; k++) begin
			if (k < 6) v = edges[k];
			else v = $signed(randBits(32)) >>> randBits(5);   // Spread the counts
			cpuWrite(gtePkg::REG_LZCS, v);
			cpuRead(gtePkg::REG_LZCR, got);
			checkWord("LZCR", gtePkg::word_t'(leadBits(v)), got);
		end

		// Packed colour
		for (int k = 0; k < 8; k++) begin
			for (int j = 0; j < 3; j++) begin
				irv[j] = gtePkg::half_t'(randBits(1) ? randBits(16) : randBits(13));
				cpuWrite(gtePkg::regId_t'(gtePkg::REG_IR1 + j), {16'h0, irv[j]});
			end
			cpuRead(gtePkg::REG_ORGB, got);
			checkWord("ORGB", orgbModel(irv[0], irv[1], irv[2]), got);
			cpuRead(gtePkg::REG_IRGB, got);
			checkWord("IRGB", orgbModel(irv[0], irv[1], irv[2]), got);
		end

		// NCLIP
		for (int k = 0; k < 6; k++) begin
			for (int j = 0; j < 3; j++) begin
				v = randBits(32);
				fx[j] = v[15:0];
				fy[j] = v[31:16];
				cpuWrite(gtePkg::regId_t'(gtePkg::REG_SXY0 + j), v);
			end
			sf = randBits(1) != 0;
			lm = randBits(1) != 0;
			runCommand(gtePkg::OP_NCLIP, sf, lm);
			cpuRead(gtePkg::REG_MAC0, got);
			checkWord("MAC0", nclipModel(fx[0], fx[1], fx[2], fy[0], fy[1], fy[2]), got);
		end

		// SQR over all sf and lm pairs
		for (int mode = 0; mode < 4; mode++) begin
			for (int k = 0; k < 3; k++) begin
				for (int j = 0; j < 3; j++) begin
					irv[j] = gtePkg::half_t'(randBits(1) ? randBits(16) : randBits(7));
					cpuWrite(gtePkg::regId_t'(gtePkg::REG_IR1 + j), {16'h0, irv[j]});
				end
				runCommand(gtePkg::OP_SQR, mode[1], mode[0]);
				want = '0;
				for (int j = 0; j < 3; j++) begin
					cpuRead(gtePkg::regId_t'(gtePkg::REG_IR1 + j), got);
					checkWord($sformatf("IR%0d", j + 1),
						sqrLane(irv[j], mode[1], mode[0], sat[j]), got);
					if (sat[j]) want[24 - j] = 1'b1;
				end
				if (want != 0) want[31] = 1'b1;   // Summary bit
				cpuRead(gtePkg::REG_FLAG, got);
				checkWord("FLAG", want, got);
			end
		end

		// AVSZ3, last pass forces a negative clamp
		for (int k = 0; k < 10; k++) begin
			for (int j = 0; j < 3; j++) begin
				sz[j] = gtePkg::half_t'(randBits(16));
				cpuWrite(gtePkg::regId_t'(gtePkg::REG_SZ1 + j), {16'h0, sz[j]});
			end
			if (k == 9) zsf = 16'h8000;
			else zsf = gtePkg::half_t'(randBits(1) ? randBits(16) : randBits(12));
			cpuWrite(gtePkg::REG_ZSF3, {16'h0, zsf});
			sf = randBits(1) != 0;
			lm = randBits(1) != 0;
			runCommand(gtePkg::OP_AVSZ3, sf, lm);
			avsz3Model(sz[0], sz[1], sz[2], zsf, want, otzWant, otzSat);
			cpuRead(gtePkg::REG_MAC0, got);
			checkWord("MAC0", want, got);
			cpuRead(gtePkg::REG_OTZ, got);
			checkHalf("OTZ", otzWant, got[15:0]);
			checkHalf("OTZ upper", 16'h0, got[31:16]);
			cpuRead(gtePkg::REG_FLAG, got);
			checkWord("FLAG", otzSat ? 32'h80040000 : 32'h0, got);
		end

		// Unknown opcode runs a no-op and clears FLAG
		runCommand(6'h00, 1'b0, 1'b0);
		cpuRead(gtePkg::REG_FLAG, got);
		checkWord("FLAG after restart", '0, got);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
